/* compile.f */
+incdir+source
source/cpu_pkg.sv
source/register_file.sv
source/alu.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/hazard_unit.sv
source/cpu.sv
test/cpu_sva.sv
test/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpu testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module cpu_tb \
	--Mdir obj_dir -o cpu_sim

./obj_dir/cpu_sim | tee sim.log

grep -q "TEST RESULT: PASS" sim.log

/* source/alu.sv */
`include "cpu_macros.svh"

module alu (
	input  logic [`CPU_XLEN-1:0] in_a,
	input  logic [`CPU_XLEN-1:0] in_b,
	input  logic [2:0]           op,      // instr[14:12]
	output logic [`CPU_XLEN-1:0] result,
	output cpu_pkg::flags_t      flags,
	output logic [2:0]           flag_we  // {z, v, n}
);

	logic [`CPU_XLEN-1:0]   sum;
	logic [`CPU_XLEN-1:0]   diff;
	logic [2*`CPU_XLEN-1:0] rot;
	logic                   add_pos, add_neg;
	logic                   sub_pos, sub_neg;
	logic                   ovf;

	assign sum  = in_a + in_b;
	assign diff = in_a - in_b;

	// Overflow direction from operand and result signs
	assign add_pos = ~in_a[`CPU_XLEN-1] & ~in_b[`CPU_XLEN-1] & sum[`CPU_XLEN-1];
	assign add_neg = in_a[`CPU_XLEN-1] & in_b[`CPU_XLEN-1] & ~sum[`CPU_XLEN-1];
	assign sub_pos = ~in_a[`CPU_XLEN-1] & in_b[`CPU_XLEN-1] & diff[`CPU_XLEN-1];
	assign sub_neg = in_a[`CPU_XLEN-1] & ~in_b[`CPU_XLEN-1] & ~diff[`CPU_XLEN-1];

	assign rot = {in_a, in_a} >> in_b[3:0]; // Low half is the rotate

	always_comb begin
		result  = '0;
		ovf     = 1'b0;
		flag_we = 3'b000; // RED, PADDSB: zero result, flags untouched
		case ({1'b0, op})
			`OP_ADD: begin
				ovf     = add_pos | add_neg;
				result  = add_pos ? {1'b0, {(`CPU_XLEN-1){1'b1}}} : // Clamp to 7FFF
					add_neg ? {1'b1, {(`CPU_XLEN-1){1'b0}}} : sum;   // or 8000
				flag_we = 3'b111;
			end
			`OP_SUB: begin
				ovf     = sub_pos | sub_neg;
				result  = sub_pos ? {1'b0, {(`CPU_XLEN-1){1'b1}}} :
					sub_neg ? {1'b1, {(`CPU_XLEN-1){1'b0}}} : diff;
				flag_we = 3'b111;
			end
			`OP_XOR: begin result = in_a ^ in_b;                        flag_we = 3'b100; end
			`OP_SLL: begin result = in_a << in_b[3:0];                  flag_we = 3'b100; end
			`OP_SRA: begin result = $signed(in_a) >>> in_b[3:0];        flag_we = 3'b100; end
			`OP_ROR: begin result = rot[`CPU_XLEN-1:0];                 flag_we = 3'b100; end
			default: ;
		endcase
	end

	assign flags.zero     = (result == '0);
	assign flags.overflow = ovf;
	assign flags.negative = result[`CPU_XLEN-1];

endmodule

/* source/cpu.sv */
`include "cpu_macros.svh"

module cpu (
	input  logic                 clk,
	input  logic                 rst_n,
	output logic [`CPU_XLEN-1:0] pc_out,
	input  logic [`CPU_XLEN-1:0] imem_data,
	output cpu_pkg::dmem_req_t   dmem_req,
	input  logic [`CPU_XLEN-1:0] dmem_rdata,
	output logic                 hlt
);

	// Pipeline registers between stages
	cpu_pkg::if_id_t      if_id;
	cpu_pkg::id_ex_t      id_ex;
	cpu_pkg::ex_mem_t     ex_mem;
	cpu_pkg::mem_wb_t     mem_wb;

	// Hazard and control
	cpu_pkg::fwd_sel_e    fwd_a, fwd_b;
	logic                 stall, halt, is_halt;
	logic                 branch_taken; // Doubles as the flush
	logic [`CPU_XLEN-1:0] branch_target;
	logic [`CPU_RSEL-1:0] src1, src2;
	logic [`CPU_XLEN-1:0] mem_fwd;

	fetch_stage u_fetch (
		.clk(clk), .rst_n(rst_n), .stall(stall), .halt(halt),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.imem_data(imem_data), .pc_out(pc_out), .if_id(if_id)
	);

	decode_stage u_decode (
		.clk(clk), .rst_n(rst_n), .if_id(if_id), .stall(stall),
		.flush(branch_taken), .wb(mem_wb), .id_ex(id_ex),
		.src1(src1), .src2(src2), .is_halt(is_halt)
	);

	execute_stage u_execute (
		.clk(clk), .rst_n(rst_n), .id_ex(id_ex), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.mem_fwd(mem_fwd), .wb_fwd(mem_wb.data), .ex_mem(ex_mem),
		.branch_taken(branch_taken), .branch_target(branch_target)
	);

	memory_stage u_memory (
		.clk(clk), .rst_n(rst_n), .ex_mem(ex_mem), .dmem_rdata(dmem_rdata),
		.dmem_req(dmem_req), .mem_fwd(mem_fwd), .mem_wb(mem_wb)
	);

	// Writeback is the MEM/WB output itself, into decode and forwarding
	hazard_unit u_hazard (
		.clk(clk), .rst_n(rst_n), .id_ex(id_ex), .ex_mem(ex_mem),
		.mem_wb(mem_wb), .src1(src1), .src2(src2), .is_halt(is_halt),
		.flush(branch_taken), .fwd_a(fwd_a), .fwd_b(fwd_b),
		.stall(stall), .halt(halt), .hlt(hlt)
	);

endmodule

/* source/cpu_macros.svh */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and register file sizing
`define CPU_XLEN 16 // Data, address and instruction width
`define CPU_NREG 16 // Architectural registers, r0 tied to zero
`define CPU_RSEL 4  // Register select width

// ----------------------------------------------------------------------
// Opcodes, instr[15:12]
// ----------------------------------------------------------------------
`define OP_ADD    4'h0 // Saturating
`define OP_SUB    4'h1 // Saturating
`define OP_XOR    4'h2
`define OP_RED    4'h3 // Not implemented, no-op
`define OP_SLL    4'h4
`define OP_SRA    4'h5
`define OP_ROR    4'h6
`define OP_PADDSB 4'h7 // Not implemented, no-op
`define OP_LW     4'h8
`define OP_SW     4'h9
`define OP_LHB    4'hA
`define OP_LLB    4'hB
`define OP_B      4'hC
`define OP_BR     4'hD
`define OP_PCS    4'hE
`define OP_HLT    4'hF

// Branch conditions, instr[11:9]
`define CC_NE     3'b000
`define CC_EQ     3'b001
`define CC_GT     3'b010
`define CC_LT     3'b011
`define CC_GE     3'b100
`define CC_LE     3'b101
`define CC_OVFL   3'b110
`define CC_UNCOND 3'b111

`endif

/* source/cpu_pkg.sv */
`include "cpu_macros.svh"

package cpu_pkg;

	// Flag register, field order matches the ALU flag_we bits {z, v, n}
	typedef struct packed {
		logic zero;
		logic overflow;
		logic negative;
	} flags_t;

	typedef struct packed {
		logic reg_write; // Result goes back to the register file
		logic mem_read;  // LW
		logic mem_write; // SW
	} ctrl_t;

	// ----------------------------------------------------------------------
	// Pipeline registers
	// ----------------------------------------------------------------------
	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc_plus_2;
		logic [`CPU_XLEN-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic                 valid;     // Zero for bubbles and flushed slots
		ctrl_t                ctrl;
		logic [`CPU_XLEN-1:0] pc_plus_2; // PCS result and branch base
		logic [`CPU_XLEN-1:0] instr;
		logic [`CPU_XLEN-1:0] data1;
		logic [`CPU_XLEN-1:0] data2;
		logic [`CPU_RSEL-1:0] src1;      // Kept for forwarding compares
		logic [`CPU_RSEL-1:0] src2;
		logic [`CPU_RSEL-1:0] dst;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                ctrl;
		logic                 halt;       // HLT riding down as a bubble
		logic [`CPU_XLEN-1:0] result;
		logic [`CPU_XLEN-1:0] addr;       // Word aligned data address
		logic [`CPU_XLEN-1:0] store_data;
		logic [`CPU_RSEL-1:0] dst;
	} ex_mem_t;

	typedef struct packed {
		logic                 reg_write;
		logic                 halt;
		logic [`CPU_XLEN-1:0] data;
		logic [`CPU_RSEL-1:0] dst;
	} mem_wb_t;

	// Data memory request, single cycle, no handshake
	typedef struct packed {
		logic                 re;
		logic                 we;
		logic [`CPU_XLEN-1:0] addr;
		logic [`CPU_XLEN-1:0] wdata;
	} dmem_req_t;

	typedef enum logic [1:0] {
		FWD_NONE, // Register file value from decode
		FWD_MEM,  // Result sitting in EX/MEM
		FWD_WB    // Result sitting in MEM/WB
	} fwd_sel_e;

endpackage

/* source/decode_stage.sv */
`include "cpu_macros.svh"

module decode_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_pkg::if_id_t      if_id,
	input  logic                 stall,
	input  logic                 flush,
	input  cpu_pkg::mem_wb_t     wb,      // Write port from MEM/WB
	output cpu_pkg::id_ex_t      id_ex,
	output logic [`CPU_RSEL-1:0] src1,
	output logic [`CPU_RSEL-1:0] src2,
	output logic                 is_halt
);

	logic [3:0]           opcode;
	logic                 is_sw, is_lw, is_imm_byte;
	cpu_pkg::ctrl_t       ctrl;
	logic [`CPU_XLEN-1:0] rd_data1, rd_data2;

	assign opcode      = if_id.instr[15:12];
	assign is_sw       = (opcode == `OP_SW);
	assign is_lw       = (opcode == `OP_LW);
	assign is_imm_byte = (opcode == `OP_LHB) || (opcode == `OP_LLB);
	assign is_halt     = if_id.valid && (opcode == `OP_HLT);

	// SW data and LHB/LLB merge source come from the dst field
	assign src1 = (is_sw || is_imm_byte) ? if_id.instr[11:8] : if_id.instr[7:4];
	assign src2 = (is_sw || is_lw) ? if_id.instr[7:4] : if_id.instr[3:0]; // Base reg

	always_comb begin
		ctrl = '0;
		case (opcode)
			`OP_ADD, `OP_SUB, `OP_XOR, `OP_SLL, `OP_SRA, `OP_ROR,
			`OP_LHB, `OP_LLB, `OP_PCS: ctrl.reg_write = if_id.valid;
			`OP_LW: begin
				ctrl.reg_write = if_id.valid;
				ctrl.mem_read  = if_id.valid;
			end
			`OP_SW:  ctrl.mem_write = if_id.valid;
			default: ctrl = '0; // RED, PADDSB, branches, HLT
		endcase
	end

	register_file u_regs (
		.clk(clk), .rst_n(rst_n),
		.rd_sel1(src1), .rd_sel2(src2),
		.wr_en(wb.reg_write), .wr_sel(wb.dst), .wr_data(wb.data),
		.rd_data1(rd_data1), .rd_data2(rd_data2)
	);

	// ID/EX register, a bubble on stall, cleared on flush
	always_ff @(posedge clk) begin
		if (!rst_n || flush || stall) begin
			id_ex <= '0;
		end else begin
			id_ex <= '{valid: if_id.valid, ctrl: ctrl, pc_plus_2: if_id.pc_plus_2,
				instr: if_id.instr, data1: rd_data1, data2: rd_data2,
				src1: src1, src2: src2, dst: if_id.instr[11:8]};
		end
	end

endmodule

/* source/execute_stage.sv */
`include "cpu_macros.svh"

module execute_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_pkg::id_ex_t      id_ex,
	input  cpu_pkg::fwd_sel_e    fwd_a,
	input  cpu_pkg::fwd_sel_e    fwd_b,
	input  logic [`CPU_XLEN-1:0] mem_fwd,      // Value leaving MEM
	input  logic [`CPU_XLEN-1:0] wb_fwd,       // MEM/WB data
	output cpu_pkg::ex_mem_t     ex_mem,
	output logic                 branch_taken,
	output logic [`CPU_XLEN-1:0] branch_target
);

	logic [3:0]           opcode;
	logic [`CPU_XLEN-1:0] op_a, op_b, alu_b;
	logic [`CPU_XLEN-1:0] alu_result, result, addr;
	cpu_pkg::flags_t      alu_flags;
	cpu_pkg::flags_t      flags_q;
	logic [2:0]           alu_we;
	logic                 is_shift, cond_true;

	assign opcode   = id_ex.instr[15:12];
	assign is_shift = (opcode == `OP_SLL) || (opcode == `OP_SRA) || (opcode == `OP_ROR);

	// ----------------------------------------------------------------------
	// Operand forwarding
	// ----------------------------------------------------------------------
	always_comb begin
		case (fwd_a)
			cpu_pkg::FWD_MEM: op_a = mem_fwd;
			cpu_pkg::FWD_WB:  op_a = wb_fwd;
			default:          op_a = id_ex.data1;
		endcase
		case (fwd_b)
			cpu_pkg::FWD_MEM: op_b = mem_fwd;
			cpu_pkg::FWD_WB:  op_b = wb_fwd;
			default:          op_b = id_ex.data2;
		endcase
	end

	assign alu_b = is_shift ? {{(`CPU_XLEN-4){1'b0}}, id_ex.instr[3:0]} : op_b; // Shift amount

	alu u_alu (
		.in_a(op_a), .in_b(alu_b), .op(id_ex.instr[14:12]),
		.result(alu_result), .flags(alu_flags), .flag_we(alu_we)
	);

	always_comb begin
		case (opcode)
			`OP_LHB: result = {id_ex.instr[7:0], op_a[7:0]}; // New high byte
			`OP_LLB: result = {op_a[15:8], id_ex.instr[7:0]}; // New low byte
			`OP_PCS: result = id_ex.pc_plus_2;
			default: result = alu_result;
		endcase
	end

	// Base with bit 0 cleared plus offset times two
	assign addr = (op_b & ~`CPU_XLEN'd1) + {{11{id_ex.instr[3]}}, id_ex.instr[3:0], 1'b0};

	// Flag register, only real ALU ops write it
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			flags_q <= '0;
		end else if (id_ex.valid && !id_ex.instr[15]) begin
			if (alu_we[2]) flags_q.zero     <= alu_flags.zero;
			if (alu_we[1]) flags_q.overflow <= alu_flags.overflow;
			if (alu_we[0]) flags_q.negative <= alu_flags.negative;
		end
	end

	// ----------------------------------------------------------------------
	// Branch resolution
	// ----------------------------------------------------------------------
	always_comb begin
		case (id_ex.instr[11:9])
			`CC_NE:   cond_true = ~flags_q.zero;
			`CC_EQ:   cond_true = flags_q.zero;
			`CC_GT:   cond_true = ~flags_q.zero & ~flags_q.negative;
			`CC_LT:   cond_true = flags_q.negative;
			`CC_GE:   cond_true = flags_q.zero | ~flags_q.negative;
			`CC_LE:   cond_true = flags_q.zero | flags_q.negative;
			`CC_OVFL: cond_true = flags_q.overflow;
			default:  cond_true = 1'b1; // Unconditional
		endcase
	end

	assign branch_taken  = id_ex.valid && cond_true && (opcode == `OP_B || opcode == `OP_BR);
	assign branch_target = (opcode == `OP_BR) ? op_a :
		id_ex.pc_plus_2 + {{6{id_ex.instr[8]}}, id_ex.instr[8:0], 1'b0};

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else begin
			ex_mem <= '{ctrl: id_ex.ctrl, halt: id_ex.valid && (opcode == `OP_HLT),
				result: result, addr: addr, store_data: op_a, dst: id_ex.dst};
		end
	end

endmodule

/* source/fetch_stage.sv */
`include "cpu_macros.svh"

module fetch_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,         // Load-use or halt freeze
	input  logic                 halt,
	input  logic                 branch_taken,  // Also the flush
	input  logic [`CPU_XLEN-1:0] branch_target,
	input  logic [`CPU_XLEN-1:0] imem_data,     // Comes back the same cycle
	output logic [`CPU_XLEN-1:0] pc_out,
	output cpu_pkg::if_id_t      if_id
);

	logic [`CPU_XLEN-1:0] pc;
	logic [`CPU_XLEN-1:0] pc_plus_2;
	logic                 hold;

	assign pc_plus_2 = pc + `CPU_XLEN'd2;
	assign hold      = stall | halt;
	assign pc_out    = pc;

	// PC, redirect beats any hold
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
		end else if (branch_taken) begin
			pc <= branch_target;
		end else if (!hold) begin
			pc <= pc_plus_2;
		end
	end

	// ----------------------------------------------------------------------
	// IF/ID register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n || branch_taken) begin
			if_id <= '0; // Squash the wrong-path word
		end else if (!hold) begin
			if_id.valid     <= 1'b1;
			if_id.pc_plus_2 <= pc_plus_2;
			if_id.instr     <= imem_data;
		end
	end

endmodule

/* source/hazard_unit.sv */
`include "cpu_macros.svh"

module hazard_unit (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_pkg::id_ex_t      id_ex,
	input  cpu_pkg::ex_mem_t     ex_mem,
	input  cpu_pkg::mem_wb_t     mem_wb,
	input  logic [`CPU_RSEL-1:0] src1,    // Decode selects
	input  logic [`CPU_RSEL-1:0] src2,
	input  logic                 is_halt,
	input  logic                 flush,
	output cpu_pkg::fwd_sel_e    fwd_a,
	output cpu_pkg::fwd_sel_e    fwd_b,
	output logic                 stall,
	output logic                 halt,
	output logic                 hlt
);

	logic load_use;
	logic halt_q; // HLT seen in decode, front end frozen
	logic hlt_q;  // HLT reached MEM/WB

	// Youngest producer first, r0 never forwarded
	function automatic cpu_pkg::fwd_sel_e fwd_pick(input logic [`CPU_RSEL-1:0] src);
		if (src == '0) return cpu_pkg::FWD_NONE;
		if (ex_mem.ctrl.reg_write && ex_mem.dst == src) return cpu_pkg::FWD_MEM;
		if (mem_wb.reg_write && mem_wb.dst == src) return cpu_pkg::FWD_WB;
		return cpu_pkg::FWD_NONE;
	endfunction

	always_comb begin
		fwd_a = fwd_pick(id_ex.src1);
		fwd_b = fwd_pick(id_ex.src2);
	end

	// Load in EX feeding decode, one bubble
	assign load_use = id_ex.ctrl.mem_read && id_ex.dst != '0 &&
		(id_ex.dst == src1 || id_ex.dst == src2);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			halt_q <= 1'b0;
			hlt_q  <= 1'b0;
		end else begin
			if (is_halt && !flush && !load_use) halt_q <= 1'b1; // Sticky
			if (mem_wb.halt) hlt_q <= 1'b1;
		end
	end

	assign stall = load_use | halt_q; // Halt keeps bubbling ID/EX
	assign halt  = halt_q;
	assign hlt   = mem_wb.halt | hlt_q;

endmodule

/* source/memory_stage.sv */
`include "cpu_macros.svh"

module memory_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  cpu_pkg::ex_mem_t     ex_mem,
	input  logic [`CPU_XLEN-1:0] dmem_rdata, // Same-cycle read data
	output cpu_pkg::dmem_req_t   dmem_req,
	output logic [`CPU_XLEN-1:0] mem_fwd,
	output cpu_pkg::mem_wb_t     mem_wb
);

	// Request straight from EX/MEM control
	assign dmem_req.re    = ex_mem.ctrl.mem_read;
	assign dmem_req.we    = ex_mem.ctrl.mem_write;
	assign dmem_req.addr  = ex_mem.addr;
	assign dmem_req.wdata = ex_mem.store_data;

	// Load data or EX result, also the EX/MEM forward path
	assign mem_fwd = ex_mem.ctrl.mem_read ? dmem_rdata : ex_mem.result;

	// ----------------------------------------------------------------------
	// MEM/WB register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else begin
			mem_wb.reg_write <= ex_mem.ctrl.reg_write;
			mem_wb.halt      <= ex_mem.halt; // Raises hlt at the output
			mem_wb.data      <= mem_fwd;
			mem_wb.dst       <= ex_mem.dst;
		end
	end

endmodule

/* source/register_file.sv */
`include "cpu_macros.svh"

module register_file (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`CPU_RSEL-1:0] rd_sel1,
	input  logic [`CPU_RSEL-1:0] rd_sel2,
	input  logic                 wr_en,
	input  logic [`CPU_RSEL-1:0] wr_sel,
	input  logic [`CPU_XLEN-1:0] wr_data,
	output logic [`CPU_XLEN-1:0] rd_data1,
	output logic [`CPU_XLEN-1:0] rd_data2
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && wr_sel != '0) begin // r0 never written
			regs[wr_sel] <= wr_data;
		end
	end

	// Write-through so decode sees the WB value in the same cycle
	assign rd_data1 = (rd_sel1 == '0) ? '0 :
		(wr_en && wr_sel == rd_sel1) ? wr_data : regs[rd_sel1];
	assign rd_data2 = (rd_sel2 == '0) ? '0 :
		(wr_en && wr_sel == rd_sel2) ? wr_data : regs[rd_sel2];

endmodule

/* test/cpu_sva.sv */
module cpu_sva (
	input logic               clk,
	input logic               rst_n,
	input cpu_pkg::dmem_req_t dmem_req,
	input logic               hlt
);

	// Read and write strobes are exclusive
	property p_re_we_excl;
		@(posedge clk) disable iff (!rst_n) !(dmem_req.re && dmem_req.we);
	endproperty
	a_re_we_excl: assert property (p_re_we_excl)
		else $error("dmem re and we high together");

	// hlt is sticky until reset
	property p_hlt_sticky;
		@(posedge clk) disable iff (!rst_n) hlt |=> hlt;
	endproperty
	a_hlt_sticky: assert property (p_hlt_sticky)
		else $error("hlt dropped without reset");

	// Nothing leaves the core in the first cycle out of reset
	property p_quiet_after_reset;
		@(posedge clk) $rose(rst_n) |-> (!dmem_req.we && !hlt);
	endproperty
	a_quiet_after_reset: assert property (p_quiet_after_reset)
		else $error("store or hlt in first cycle after reset");

endmodule

bind cpu cpu_sva u_sva (.clk(clk), .rst_n(rst_n), .dmem_req(dmem_req), .hlt(hlt));

/* test/cpu_tb.sv */
`include "cpu_macros.svh"

module cpu_tb;

	logic               clk;
	logic               rst_n;
	logic [15:0]        pc_out;
	logic [15:0]        imem_data;
	cpu_pkg::dmem_req_t dmem_req;
	logic [15:0]        dmem_rdata;
	logic               hlt;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [15:0] prog [$];     // Program being built
	logic        preload_en;   // Extra data word applied during reset
	logic [7:0]  preload_idx;
	logic [15:0] preload_val;
	int          store_count;  // Stores seen on dmem_req since reset
	int          load_count;   // Loads seen on dmem_req since reset
	int          run_cycles;   // Cycles from reset release until hlt
	logic [15:0] lfsr_state;
	int          errors, tests_run, tests_failed;

	cpu dut0 (
		.clk(clk), .rst_n(rst_n), .pc_out(pc_out), .imem_data(imem_data),
		.dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .hlt(hlt)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Memory models read combinationally
	// ----------------------------------------------------------------------
	assign imem_data  = imem[pc_out[8:1]];
	assign dmem_rdata = dmem[dmem_req.addr[8:1]];

	function automatic logic [15:0] fill_word(input logic [7:0] idx);
		return {idx, ~idx}; // Unwritten words are recognizable
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 256; i++) dmem[i] <= fill_word(i[7:0]);
			if (preload_en) dmem[preload_idx] <= preload_val;
			store_count <= 0;
			load_count  <= 0;
		end else begin
			if (dmem_req.we) begin
				dmem[dmem_req.addr[8:1]] <= dmem_req.wdata; // Word address
				store_count <= store_count + 1;
			end
			if (dmem_req.re) load_count <= load_count + 1;
		end
	end

	// 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	// ----------------------------------------------------------------------
	// Reference arithmetic
	// ----------------------------------------------------------------------
	function automatic logic [16:0] sat_add(input logic [15:0] a, input logic [15:0] b);
		int s;
		s = $signed(a) + $signed(b);
		if (s > 32767) return {1'b1, 16'h7FFF}; // Top bit is overflow
		if (s < -32768) return {1'b1, 16'h8000};
		return {1'b0, s[15:0]};
	endfunction

	function automatic logic [16:0] sat_sub(input logic [15:0] a, input logic [15:0] b);
		int s;
		s = $signed(a) - $signed(b);
		if (s > 32767) return {1'b1, 16'h7FFF};
		if (s < -32768) return {1'b1, 16'h8000};
		return {1'b0, s[15:0]};
	endfunction

	function automatic logic cond_met(input logic [2:0] cc, input logic z, v, n);
		case (cc)
			`CC_NE:  return !z;
			`CC_EQ:  return z;
			`CC_GT:  return !z && !n;
			`CC_LT:  return n;
			`CC_GE:  return z || !n;
			`CC_LE:  return z || n;
			`CC_OVFL: return v;
			default: return 1'b1;
		endcase
	endfunction

	// Instruction encoders
	function automatic logic [15:0] rtype(input logic [3:0] op, d, s, t);
		return {op, d, s, t};
	endfunction

	function automatic logic [15:0] itype(input logic [3:0] op, d, input logic [7:0] imm);
		return {op, d, imm};
	endfunction

	task automatic emit(input logic [15:0] w);
		prog.push_back(w);
	endtask

	task automatic set_reg(input logic [3:0] r, input logic [15:0] val);
		emit(itype(`OP_LLB, r, val[7:0]));
		emit(itype(`OP_LHB, r, val[15:8]));
	endtask

	task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
		if (act !== exp) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// ----------------------------------------------------------------------
	// Load, reset, run until hlt
	// ----------------------------------------------------------------------
	task automatic run_program(input string name);
		int cycles;
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : {4'h3, 4'h0, i[7:0]}; // RED no-op
		end
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!hlt && cycles < 200) begin
			@(negedge clk);
			cycles++;
		end
		run_cycles = cycles;
		if (!hlt) begin
			$display("%s: processor never raised hlt within 200 cycles", name);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests_run++;
		if (errors > err_before) begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - err_before);
		end else begin
			$display("%s: ok", name);
		end
	endtask

	// ----------------------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------------------
	task automatic arith_forwarding();
		logic [15:0] a, b, e1, e2, e3;
		logic [16:0] r;
		int          e0;
		e0 = errors;
		a  = rand_bits(16);
		b  = rand_bits(16);
		r  = sat_add(a, b);
		e1 = r[15:0];
		r  = sat_sub(e1, a);
		e2 = r[15:0];
		e3 = e2 ^ e1;
		prog.delete();
		set_reg(1, a);
		set_reg(2, b);
		emit(rtype(`OP_ADD, 3, 1, 2)); // Back to back dependent chain
		emit(rtype(`OP_SUB, 4, 3, 1)); // r3 from EX/MEM
		emit(rtype(`OP_XOR, 5, 4, 3)); // r4 from EX/MEM and r3 from MEM/WB
		emit(rtype(`OP_SW, 3, 0, 0));
		emit(rtype(`OP_SW, 4, 0, 1));
		emit(rtype(`OP_SW, 5, 0, 2));
		emit(16'hF000);
		run_program("arith");
		check_eq("arith add", e1, dmem[0]);
		check_eq("arith sub", e2, dmem[1]);
		check_eq("arith xor", e3, dmem[2]);
		check_eq("arith stores", 16'd3, store_count[15:0]);
		finish_test("arith", e0);
	endtask

	task automatic load_use_stall();
		logic [15:0] x, y;
		logic [16:0] s;
		int          e0;
		e0 = errors;
		x  = rand_bits(16);
		y  = rand_bits(16);
		s  = sat_add(x, y);
		preload_en  = 1'b1;
		preload_idx = 8'd8; // Byte address 16
		preload_val = x;
		prog.delete();
		set_reg(2, y);
		emit(itype(`OP_LLB, 6, 8'd16));
		emit(rtype(`OP_LW, 1, 6, 0));
		emit(rtype(`OP_ADD, 3, 1, 2)); // Needs the loaded value so one stall
		emit(rtype(`OP_SW, 3, 0, 1));
		emit(16'hF000);
		run_program("load_use");
		preload_en = 1'b0;
		check_eq("load_use sum", s[15:0], dmem[1]);
		check_eq("load_use loads", 16'd1, load_count[15:0]);
		// HLT sits at index 6, hlt follows four edges later plus one stall
		check_eq("load_use cycles to hlt", 16'd11, run_cycles[15:0]);
		finish_test("load_use", e0);
	endtask

	task automatic shift_merge();
		logic [15:0] a;
		logic [3:0]  s1, s2, s3;
		logic [7:0]  hb;
		int          e0;
		e0 = errors;
		a  = rand_bits(16);
		s1 = rand_bits(4);
		s2 = rand_bits(4);
		s3 = rand_bits(4);
		hb = rand_bits(8);
		prog.delete();
		set_reg(1, a);
		emit(rtype(`OP_SLL, 2, 1, s1));
		emit(rtype(`OP_SRA, 3, 1, s2));
		emit(rtype(`OP_ROR, 4, 1, s3));
		emit(itype(`OP_LHB, 1, hb)); // Merge new high byte
		emit(rtype(`OP_SW, 2, 0, 0));
		emit(rtype(`OP_SW, 3, 0, 1));
		emit(rtype(`OP_SW, 4, 0, 2));
		emit(rtype(`OP_SW, 1, 0, 3));
		emit(16'hF000);
		run_program("shifts");
		check_eq("shifts sll", a << s1, dmem[0]);
		// Logical shift with the vacated top bits filled from the sign
		check_eq("shifts sra", (a >> s2) | (~(16'hFFFF >> s2) & {16{a[15]}}), dmem[1]);
		check_eq("shifts ror", (a >> s3) | (a << (16 - s3)), dmem[2]);
		check_eq("shifts lhb", {hb, a[7:0]}, dmem[3]);
		finish_test("shifts", e0);
	endtask

	task automatic branch_conditions();
		logic [15:0] a, b;
		logic [16:0] r;
		logic        taken [8];
		int          exp_stores;
		int          e0;
		e0 = errors;
		exp_stores = 0;
		prog.delete();
		emit(itype(`OP_LLB, 8, 8'hA5)); // Store marker
		for (int i = 0; i < 8; i++) begin
			a = rand_bits(16);
			b = rand_bits(16);
			if (i == 1) b = a;               // EQ taken
			if (i == 6) begin
				a = 16'h7000;                // Overflow taken
				b = 16'h7000;
			end
			r = (i % 2 == 0) ? sat_add(a, b) : sat_sub(a, b);
			taken[i] = cond_met(i[2:0], r[15:0] == 16'h0, r[16], r[15]);
			if (!taken[i]) exp_stores += 2;
			set_reg(1, a);
			set_reg(2, b);
			emit(itype(`OP_LLB, 9, 8'(4 * i)));
			emit(rtype((i % 2 == 0) ? `OP_ADD : `OP_SUB, 7, 1, 2));
			emit({`OP_B, i[2:0], 9'd2}); // Skip both stores
			emit(rtype(`OP_SW, 8, 9, 0));
			emit(rtype(`OP_SW, 8, 9, 1));
		end
		emit(16'hF000);
		run_program("branches");
		for (int i = 0; i < 8; i++) begin
			check_eq($sformatf("branch cc%0d first", i),
				taken[i] ? fill_word(8'(2 * i)) : 16'h00A5, dmem[2 * i]);
			check_eq($sformatf("branch cc%0d second", i),
				taken[i] ? fill_word(8'(2 * i + 1)) : 16'h00A5, dmem[2 * i + 1]);
		end
		check_eq("branch stores", 16'(exp_stores), store_count[15:0]);
		finish_test("branches", e0);
	endtask

	task automatic jump_and_pcs();
		int e0;
		e0 = errors;
		prog.delete();
		emit(itype(`OP_LLB, 1, 8'h20));     // 0x00
		emit(itype(`OP_PCS, 2, 8'h00));     // At 0x02 yields 4
		emit({`OP_BR, 3'b111, 1'b0, 4'd1, 4'h0});
		emit(itype(`OP_LLB, 8, 8'h55));     // Must be skipped
		emit(rtype(`OP_SW, 8, 0, 3));
		while (prog.size() < 16) emit(16'h3000);
		emit(rtype(`OP_SW, 2, 0, 0));       // 0x20
		emit(itype(`OP_PCS, 3, 8'h00));     // At 0x22 yields 0x24
		emit(rtype(`OP_SW, 3, 0, 1));
		emit(16'hF000);
		run_program("br_pcs");
		check_eq("br_pcs first pcs", 16'h0004, dmem[0]);
		check_eq("br_pcs second pcs", 16'h0024, dmem[1]);
		check_eq("br_pcs skipped store", fill_word(8'd3), dmem[3]);
		check_eq("br_pcs stores", 16'd2, store_count[15:0]);
		finish_test("br_pcs", e0);
	endtask

	task automatic halt_freeze();
		logic [15:0] v, pc_hold;
		int          e0;
		e0 = errors;
		v  = rand_bits(16);
		prog.delete();
		set_reg(1, v);
		emit(rtype(`OP_SW, 1, 0, 2));
		emit(16'hF000);
		run_program("halt");
		check_eq("halt store", v, dmem[2]);
		pc_hold = pc_out;
		for (int i = 0; i < 20; i++) begin
			@(negedge clk);
			if (!hlt) begin
				$display("halt: hlt dropped %0d cycles after rising", i + 1);
				errors++;
			end
			check_eq("halt pc frozen", pc_hold, pc_out);
		end
		finish_test("halt", e0);
	endtask

	initial begin
		rst_n        = 1'b0;
		preload_en   = 1'b0;
		preload_idx  = '0;
		preload_val  = '0;
		lfsr_state   = 16'd72;
		run_cycles   = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		for (int i = 0; i < 256; i++) imem[i] = 16'h3000;
		arith_forwarding();
		load_use_stall();
		shift_merge();
		branch_conditions();
		jump_and_pcs();
		halt_freeze();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
